//--- src/gpio_apb_regs.sv
/*
 * APB register file of the GPIO peripheral
 * Byte-strobed configuration writes, status clear mask and registered reads
 */
module gpio_apb_regs #(
  parameter int PDATA_SIZE = 16,
  parameter int PADDR_SIZE = 4
) (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  gpio_bus_pkg::apb_ctrl_t apb_ctrl,
  input  logic [PADDR_SIZE-1:0]   paddr,
  input  logic [PDATA_SIZE/8-1:0] pstrb,
  input  logic [PDATA_SIZE-1:0]   pwdata,
  output logic [PDATA_SIZE-1:0]   prdata,
  input  logic [PDATA_SIZE-1:0]   in_val,
  input  logic [PDATA_SIZE-1:0]   tr_stat,
  output gpio_pin_pkg::pin_cfg_t  pin_cfg [PDATA_SIZE],
  output gpio_pin_pkg::trig_cfg_t trig_cfg [PDATA_SIZE],
  output logic [PDATA_SIZE-1:0]   stat_clear
);

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Register indices sized to the address bus
  localparam logic [PADDR_SIZE-1:0] A_MODE    = PADDR_SIZE'(gpio_bus_pkg::MODE);
  localparam logic [PADDR_SIZE-1:0] A_DIR     = PADDR_SIZE'(gpio_bus_pkg::DIRECTION);
  localparam logic [PADDR_SIZE-1:0] A_OUTPUT  = PADDR_SIZE'(gpio_bus_pkg::OUTPUT);
  localparam logic [PADDR_SIZE-1:0] A_INPUT   = PADDR_SIZE'(gpio_bus_pkg::INPUT);
  localparam logic [PADDR_SIZE-1:0] A_TR_TYPE = PADDR_SIZE'(gpio_bus_pkg::TR_TYPE);
  localparam logic [PADDR_SIZE-1:0] A_TR_LVL0 = PADDR_SIZE'(gpio_bus_pkg::TR_LVL0);
  localparam logic [PADDR_SIZE-1:0] A_TR_LVL1 = PADDR_SIZE'(gpio_bus_pkg::TR_LVL1);
  localparam logic [PADDR_SIZE-1:0] A_TR_STAT = PADDR_SIZE'(gpio_bus_pkg::TR_STAT);
  localparam logic [PADDR_SIZE-1:0] A_IRQ_ENA = PADDR_SIZE'(gpio_bus_pkg::IRQ_ENA);

  logic                  wr_en;
  logic [PDATA_SIZE-1:0] strb_mask;

  // Configuration registers, one bit per pin
  logic [PDATA_SIZE-1:0] mode_q;
  logic [PDATA_SIZE-1:0] dir_q;
  logic [PDATA_SIZE-1:0] out_q;
  logic [PDATA_SIZE-1:0] tr_type_q;
  logic [PDATA_SIZE-1:0] lvl0_q;
  logic [PDATA_SIZE-1:0] lvl1_q;
  logic [PDATA_SIZE-1:0] irq_ena_q;

  // Write lands at the end of the access phase
  assign wr_en = apb_ctrl.sel & apb_ctrl.enable & apb_ctrl.write;

  // Widen each strobe over its byte lane
  always_comb begin
    for (int n = 0; n < PDATA_SIZE / 8; n++) begin
      strb_mask[n*8 +: 8] = {8{pstrb[n]}};
    end
  end

  // Strobed lanes from the bus, others keep their value
  function automatic logic [PDATA_SIZE-1:0] merge(input logic [PDATA_SIZE-1:0] orig);
    return (orig & ~strb_mask) | (pwdata & strb_mask);
  endfunction

  //////////////////////////////
  // Register writes
  //////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      mode_q    <= '0;
      dir_q     <= '0;
      out_q     <= '0;
      tr_type_q <= '0;
      lvl0_q    <= '0;
      lvl1_q    <= '0;
      irq_ena_q <= '0;
    end else if (wr_en) begin
      case (paddr)
        A_MODE:            mode_q    <= merge(mode_q);
        A_DIR:             dir_q     <= merge(dir_q);
        // INPUT is read-only, its writes go to OUTPUT
        A_OUTPUT, A_INPUT: out_q     <= merge(out_q);
        A_TR_TYPE:         tr_type_q <= merge(tr_type_q);
        A_TR_LVL0:         lvl0_q    <= merge(lvl0_q);
        A_TR_LVL1:         lvl1_q    <= merge(lvl1_q);
        A_IRQ_ENA:         irq_ena_q <= merge(irq_ena_q);
        default:           ;
      endcase
    end
  end

  // Write-one-to-clear, only the strobed lanes
  assign stat_clear = (wr_en && paddr == A_TR_STAT) ? (pwdata & strb_mask) : '0;

  //////////////////////////////
  // Read mux
  //////////////////////////////

  // Loaded every edge, sampled by the master in the access phase
  always_ff @(posedge PCLK) begin
    case (paddr)
      A_MODE:    prdata <= mode_q;
      A_DIR:     prdata <= dir_q;
      A_OUTPUT:  prdata <= out_q;
      A_INPUT:   prdata <= in_val;
      A_TR_TYPE: prdata <= tr_type_q;
      A_TR_LVL0: prdata <= lvl0_q;
      A_TR_LVL1: prdata <= lvl1_q;
      A_TR_STAT: prdata <= tr_stat;
      A_IRQ_ENA: prdata <= irq_ena_q;
      default:   prdata <= '0;
    endcase
  end

  //////////////////////////////
  // Per-pin configuration
  //////////////////////////////

  for (genvar n = 0; n < PDATA_SIZE; n++) begin : g_cfg
    assign pin_cfg[n] = '{mode: mode_q[n], dir: dir_q[n], out: out_q[n]};
    assign trig_cfg[n] = '{
      tr_type: tr_type_q[n],
      lvl0:    lvl0_q[n],
      lvl1:    lvl1_q[n],
      irq_ena: irq_ena_q[n]
    };
  end

endmodule

//--- src/gpio_apb_top.sv
/*
 * GPIO peripheral with an APB slave port
 * Zero wait states, exports pad output and output enable per pin
 */
module gpio_apb_top #(
  parameter int PDATA_SIZE   = 16,  // Multiple of 8
  parameter int PADDR_SIZE   = 4,
  parameter int INPUT_STAGES = 2
) (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  logic                    PSEL,
  input  logic                    PENABLE,
  input  logic [PADDR_SIZE-1:0]   PADDR,
  input  logic                    PWRITE,
  input  logic [PDATA_SIZE/8-1:0] PSTRB,
  input  logic [PDATA_SIZE-1:0]   PWDATA,
  output logic [PDATA_SIZE-1:0]   PRDATA,
  output logic                    PREADY,
  output logic                    PSLVERR,
  output logic                    irq,
  input  logic [PDATA_SIZE-1:0]   gpio_i,
  output logic [PDATA_SIZE-1:0]   gpio_o,
  output logic [PDATA_SIZE-1:0]   gpio_oe
);

  gpio_bus_pkg::apb_ctrl_t apb_ctrl;
  gpio_pin_pkg::pin_cfg_t  pin_cfg [PDATA_SIZE];
  gpio_pin_pkg::trig_cfg_t trig_cfg [PDATA_SIZE];
  logic [PDATA_SIZE-1:0]   stat_clear;
  logic [PDATA_SIZE-1:0]   in_val;
  logic [PDATA_SIZE-1:0]   tr_stat;

  assign apb_ctrl = '{sel: PSEL, enable: PENABLE, write: PWRITE};

  // Never stalls, never errors
  assign PREADY  = 1'b1;
  assign PSLVERR = 1'b0;

  gpio_apb_regs #(
    .PDATA_SIZE (PDATA_SIZE),
    .PADDR_SIZE (PADDR_SIZE)
  ) gpio_apb_regs_inst (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .apb_ctrl   (apb_ctrl),
    .paddr      (PADDR),
    .pstrb      (PSTRB),
    .pwdata     (PWDATA),
    .prdata     (PRDATA),
    .in_val     (in_val),
    .tr_stat    (tr_stat),
    .pin_cfg    (pin_cfg),
    .trig_cfg   (trig_cfg),
    .stat_clear (stat_clear)
  );

  gpio_pin_io #(
    .PDATA_SIZE   (PDATA_SIZE),
    .INPUT_STAGES (INPUT_STAGES)
  ) gpio_pin_io_inst (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .pin_cfg (pin_cfg),
    .gpio_i  (gpio_i),
    .in_val  (in_val),
    .gpio_o  (gpio_o),
    .gpio_oe (gpio_oe)
  );

  gpio_trigger #(
    .PDATA_SIZE (PDATA_SIZE)
  ) gpio_trigger_inst (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .trig_cfg   (trig_cfg),
    .in_val     (in_val),
    .stat_clear (stat_clear),
    .tr_stat    (tr_stat),
    .irq        (irq)
  );

endmodule

//--- src/gpio_bus_pkg.sv
/*
 * Bus side definitions of the GPIO peripheral
 * Register indices, APB control bundle and read timing
 */
package gpio_bus_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Word index on PADDR, one register per index
  typedef enum logic [3:0] {
    MODE      = 4'd0,
    DIRECTION = 4'd1,
    OUTPUT    = 4'd2,
    INPUT     = 4'd3,
    TR_TYPE   = 4'd4,
    TR_LVL0   = 4'd5,
    TR_LVL1   = 4'd6,
    TR_STAT   = 4'd7,
    IRQ_ENA   = 4'd8
  } reg_addr_e;

  //////////////////////////////
  // APB control
  //////////////////////////////

  // Phase and direction qualifiers of one transfer
  typedef struct packed {
    logic sel;
    logic enable;
    logic write;
  } apb_ctrl_t;

  // PRDATA is loaded one edge after setup
  // and is valid throughout the access phase
  localparam int unsigned READ_LATENCY = 1;

endpackage

//--- src/gpio_pin_io.sv
/*
 * Pin interface of the GPIO peripheral
 * Synchronizes the inputs and registers the pad drive signals
 */
module gpio_pin_io #(
  parameter int PDATA_SIZE   = 16,
  parameter int INPUT_STAGES = 2
) (
  input  logic                   PCLK,
  input  logic                   PRESETn,
  input  gpio_pin_pkg::pin_cfg_t pin_cfg [PDATA_SIZE],
  input  logic [PDATA_SIZE-1:0]  gpio_i,
  output logic [PDATA_SIZE-1:0]  in_val,
  output logic [PDATA_SIZE-1:0]  gpio_o,
  output logic [PDATA_SIZE-1:0]  gpio_oe
);

  // Synchronizer chain, stage 0 faces the pins
  logic [PDATA_SIZE-1:0] sync_q [INPUT_STAGES];
  logic [PDATA_SIZE-1:0] o_next;
  logic [PDATA_SIZE-1:0] oe_next;

  //////////////////////////////
  // Input path
  //////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      for (int s = 0; s < INPUT_STAGES; s++) begin
        sync_q[s] <= '0;
      end
      in_val <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      for (int s = 1; s < INPUT_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
      // Extra register after the chain
      in_val <= sync_q[INPUT_STAGES-1];
    end
  end

  //////////////////////////////
  // Output path
  //////////////////////////////

  // Open drain never drives high, it releases the pad instead
  always_comb begin
    for (int n = 0; n < PDATA_SIZE; n++) begin
      if (pin_cfg[n].mode == gpio_pin_pkg::OPEN_DRAIN) begin
        o_next[n]  = 1'b0;
        oe_next[n] = pin_cfg[n].dir & ~pin_cfg[n].out;
      end else begin
        o_next[n]  = pin_cfg[n].out;
        oe_next[n] = pin_cfg[n].dir;
      end
    end
  end

  // All pins are inputs out of reset
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      gpio_o  <= '0;
      gpio_oe <= '0;
    end else begin
      gpio_o  <= o_next;
      gpio_oe <= oe_next;
    end
  end

endmodule

//--- src/gpio_pin_pkg.sv
/*
 * Pin side definitions of the GPIO peripheral
 * Per-pin drive and trigger configuration with their encodings
 */
package gpio_pin_pkg;

  //////////////////////////////
  // Pad driving
  //////////////////////////////

  // Output mode encoding
  localparam logic PUSH_PULL  = 1'b0;
  localparam logic OPEN_DRAIN = 1'b1;

  // Drive setup of one pin
  typedef struct packed {
    logic mode;  // PUSH_PULL or OPEN_DRAIN
    logic dir;   // 1 for output
    logic out;
  } pin_cfg_t;

  //////////////////////////////
  // Triggering
  //////////////////////////////

  // Trigger kind encoding
  localparam logic TR_LEVEL = 1'b0;
  localparam logic TR_EDGE  = 1'b1;

  // Trigger setup of one pin
  typedef struct packed {
    logic tr_type;  // TR_LEVEL or TR_EDGE
    logic lvl0;     // Low level or falling edge
    logic lvl1;     // High level or rising edge
    logic irq_ena;
  } trig_cfg_t;

endpackage

//--- src/gpio_trigger.sv
/*
 * Trigger logic of the GPIO peripheral
 * Level and edge detection per pin, sticky status and interrupt
 */
module gpio_trigger #(
  parameter int PDATA_SIZE = 16
) (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  gpio_pin_pkg::trig_cfg_t trig_cfg [PDATA_SIZE],
  input  logic [PDATA_SIZE-1:0]   in_val,
  input  logic [PDATA_SIZE-1:0]   stat_clear,
  output logic [PDATA_SIZE-1:0]   tr_stat,
  output logic                    irq
);

  logic [PDATA_SIZE-1:0] in_dly_q;
  logic [PDATA_SIZE-1:0] rise_q;
  logic [PDATA_SIZE-1:0] fall_q;
  logic [PDATA_SIZE-1:0] match;
  logic [PDATA_SIZE-1:0] irq_ena;

  //////////////////////////////
  // Edge detection
  //////////////////////////////

  // Flags compare in_val with its copy from the previous cycle
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      in_dly_q <= '0;
      rise_q   <= '0;
      fall_q   <= '0;
    end else begin
      in_dly_q <= in_val;
      rise_q   <= in_val & ~in_dly_q;
      fall_q   <= in_dly_q & ~in_val;
    end
  end

  //////////////////////////////
  // Trigger selection
  //////////////////////////////

  // lvl0 means low or falling, lvl1 means high or rising
  always_comb begin
    for (int n = 0; n < PDATA_SIZE; n++) begin
      if (trig_cfg[n].tr_type == gpio_pin_pkg::TR_EDGE) begin
        match[n] = (trig_cfg[n].lvl0 & fall_q[n]) | (trig_cfg[n].lvl1 & rise_q[n]);
      end else begin
        match[n] = (trig_cfg[n].lvl0 & ~in_val[n]) | (trig_cfg[n].lvl1 & in_val[n]);
      end
      irq_ena[n] = trig_cfg[n].irq_ena;
    end
  end

  // Sticky status, a new match wins over a clear
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      tr_stat <= '0;
      irq     <= 1'b0;
    end else begin
      tr_stat <= (tr_stat & ~stat_clear) | match;
      irq     <= |(tr_stat & irq_ena);
    end
  end

endmodule

//--- tb/gpio_tb.sv
/*
 * Testbench of the APB GPIO peripheral
 * Drives bus and pins, models registers, pads and triggers, reports every check
 */
module gpio_tb;

  localparam int PDATA_SIZE = 16;
  localparam int PADDR_SIZE = 4;
  localparam int STRB_W     = PDATA_SIZE / 8;
  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS  = 6;

  // Model selectors above the register indices
  localparam int K_GPIO_O  = 16;
  localparam int K_GPIO_OE = 17;
  localparam int K_MATCH   = 18;
  localparam int K_IRQ     = 19;

  logic                  PCLK;
  logic                  PRESETn;
  logic                  psel    = 1'b0;
  logic                  penable = 1'b0;
  logic                  pwrite  = 1'b0;
  logic [PADDR_SIZE-1:0] paddr   = '0;
  logic [STRB_W-1:0]     pstrb   = '0;
  logic [PDATA_SIZE-1:0] pwdata  = '0;
  logic [PDATA_SIZE-1:0] gpio_i  = '0;
  logic [PDATA_SIZE-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  irq;
  logic [PDATA_SIZE-1:0] gpio_o;
  logic [PDATA_SIZE-1:0] gpio_oe;

  // Model state indexed like PADDR
  // The TR_STAT slot holds the expected status
  logic [PDATA_SIZE-1:0] shadow [16];
  logic [PDATA_SIZE-1:0] pins_now;
  integer                seed = 32'h99bfd446;
  int                    n_pass;
  int                    n_fail;

  // Pending checks
  string                 name_q [$];
  bit                    bit_q [$];
  logic [PDATA_SIZE-1:0] exp_q [$];
  logic [PDATA_SIZE-1:0] act_q [$];

  gpio_tb_clk #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (8)
  ) gpio_tb_clk_inst (
    .PCLK    (PCLK),
    .PRESETn (PRESETn)
  );

  gpio_apb_top #(
    .PDATA_SIZE   (PDATA_SIZE),
    .PADDR_SIZE   (PADDR_SIZE),
    .INPUT_STAGES (2)
  ) gpio_apb_top_inst (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .PSEL    (psel),
    .PENABLE (penable),
    .PADDR   (paddr),
    .PWRITE  (pwrite),
    .PSTRB   (pstrb),
    .PWDATA  (pwdata),
    .PRDATA  (prdata),
    .PREADY  (pready),
    .PSLVERR (pslverr),
    .irq     (irq),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .gpio_oe (gpio_oe)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [PDATA_SIZE-1:0] rand_word();
    return PDATA_SIZE'($random(seed));
  endfunction

  // One byte lane per strobe bit
  function automatic logic [PDATA_SIZE-1:0] lane_mask(input logic [STRB_W-1:0] strb);
    logic [PDATA_SIZE-1:0] m;
    for (int n = 0; n < STRB_W; n++) begin
      m[n*8 +: 8] = {8{strb[n]}};
    end
    return m;
  endfunction

  // Register readback, pad drive, trigger match or irq
  function automatic logic [PDATA_SIZE-1:0] ref_model(
    input int                    kind,
    input logic [PDATA_SIZE-1:0] pins,
    input logic [PDATA_SIZE-1:0] prev
  );
    logic [PDATA_SIZE-1:0] lv0;
    logic [PDATA_SIZE-1:0] lv1;
    logic [PDATA_SIZE-1:0] mode;
    logic [PDATA_SIZE-1:0] tt;
    lv0  = shadow[gpio_bus_pkg::TR_LVL0];
    lv1  = shadow[gpio_bus_pkg::TR_LVL1];
    mode = shadow[gpio_bus_pkg::MODE];
    tt   = shadow[gpio_bus_pkg::TR_TYPE];
    case (kind)
      gpio_bus_pkg::INPUT: return pins;
      // Open drain only ever pulls low
      K_GPIO_O:  return shadow[gpio_bus_pkg::OUTPUT] & ~mode;
      K_GPIO_OE: return shadow[gpio_bus_pkg::DIRECTION] & ~(mode & shadow[gpio_bus_pkg::OUTPUT]);
      // Level when tr_type is 0, edge when 1
      K_MATCH: return (~tt & ((lv0 & ~pins) | (lv1 & pins)))
                    | (tt & ((lv0 & prev & ~pins) | (lv1 & ~prev & pins)));
      K_IRQ: return PDATA_SIZE'(|(shadow[gpio_bus_pkg::TR_STAT] & shadow[gpio_bus_pkg::IRQ_ENA]));
      default: return (kind <= int'(gpio_bus_pkg::IRQ_ENA)) ? shadow[kind] : '0;
    endcase
  endfunction

  //////////////////////////////
  // Bus and pin stimulus
  //////////////////////////////

  task automatic apb_write(input logic [PADDR_SIZE-1:0] addr,
                           input logic [PDATA_SIZE-1:0] data,
                           input logic [STRB_W-1:0]     strb);
    logic [PADDR_SIZE-1:0] dst;
    @(posedge PCLK);
    psel   <= 1'b1;
    pwrite <= 1'b1;
    paddr  <= addr;
    pwdata <= data;
    pstrb  <= strb;
    @(posedge PCLK);
    penable <= 1'b1;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    // Writes to INPUT land in OUTPUT
    dst = (addr == gpio_bus_pkg::INPUT) ? gpio_bus_pkg::OUTPUT : addr;
    if (dst == gpio_bus_pkg::TR_STAT) begin
      shadow[dst] = shadow[dst] & ~(data & lane_mask(strb));
    end else if (dst <= gpio_bus_pkg::IRQ_ENA) begin
      shadow[dst] = (shadow[dst] & ~lane_mask(strb)) | (data & lane_mask(strb));
    end
    // Stable pins keep matching under the new setup
    shadow[gpio_bus_pkg::TR_STAT] |= ref_model(K_MATCH, pins_now, pins_now);
  endtask

  task automatic apb_read(input logic [PADDR_SIZE-1:0] addr, output logic [PDATA_SIZE-1:0] data);
    @(posedge PCLK);
    psel  <= 1'b1;
    paddr <= addr;
    repeat (gpio_bus_pkg::READ_LATENCY) @(posedge PCLK);
    penable <= 1'b1;
    // Mid access phase
    @(negedge PCLK);
    data = prdata;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // New pin vector held until synchronizer, edge flags and status settle
  task automatic drive_pins(input logic [PDATA_SIZE-1:0] pins);
    @(posedge PCLK);
    gpio_i <= pins;
    repeat (8) @(posedge PCLK);
    shadow[gpio_bus_pkg::TR_STAT] |= ref_model(K_MATCH, pins, pins_now);
    pins_now = pins;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge PCLK);
    @(negedge PCLK);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic post_word(input string name, input logic [PDATA_SIZE-1:0] exp, act);
    name_q.push_back(name);
    bit_q.push_back(1'b0);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  task automatic post_bit(input string name, input logic exp, act);
    name_q.push_back(name);
    bit_q.push_back(1'b1);
    exp_q.push_back(PDATA_SIZE'(exp));
    act_q.push_back(PDATA_SIZE'(act));
  endtask

  task automatic read_check(input string name, input logic [PADDR_SIZE-1:0] addr);
    logic [PDATA_SIZE-1:0] exp;
    logic [PDATA_SIZE-1:0] act;
    exp = ref_model(int'(addr), pins_now, pins_now);
    apb_read(addr, act);
    post_word(name, exp, act);
  endtask

  task automatic check_word(input string name, input logic [PDATA_SIZE-1:0] exp, act);
    if (act === exp) begin
      n_pass++;
      $display("ok    %s = %h", name, act);
    end else begin
      n_fail++;
      $display("ERROR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input logic exp, act);
    if (act === exp) begin
      n_pass++;
      $display("ok    %s = %b", name, act);
    end else begin
      n_fail++;
      $display("ERROR %s expected %b actual %b", name, exp, act);
    end
  endtask

  // Drains the pending checks
  always @(posedge PCLK) begin : compare
    string                 name;
    bit                    is_bit;
    logic [PDATA_SIZE-1:0] exp;
    logic [PDATA_SIZE-1:0] act;
    while (name_q.size() > 0) begin
      name   = name_q.pop_front();
      is_bit = bit_q.pop_front();
      exp    = exp_q.pop_front();
      act    = act_q.pop_front();
      if (is_bit) begin
        check_irq(name, exp[0], act[0]);
      end else begin
        check_word(name, exp, act);
      end
    end
  end

  initial begin : watchdog
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Simulation timed out after %0d cycles", NUM_TESTS * 200);
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : stimulus
    logic [PADDR_SIZE-1:0] addr;
    logic [PDATA_SIZE-1:0] flip;
    for (int i = 0; i < 16; i++) begin
      shadow[i] = '0;
    end
    pins_now = '0;
    wait (PRESETn === 1'b1);

    // Register access in two rounds so strobes merge into earlier values
    for (int i = 0; i < 32; i++) begin
      addr = PADDR_SIZE'(i);
      if (addr != gpio_bus_pkg::INPUT && addr != gpio_bus_pkg::TR_STAT) begin
        apb_write(addr, rand_word(), STRB_W'($random(seed)));
        read_check($sformatf("reg %0d round %0d", addr, i / 16), addr);
      end
    end
    apb_write(gpio_bus_pkg::INPUT, rand_word(), '1);
    read_check("input alias", gpio_bus_pkg::OUTPUT);

    // Zero wait states and no slave errors
    wait_cycles(0);
    post_bit("pready", 1'b1, pready);
    post_bit("pslverr", 1'b0, pslverr);

    // Pad drive one cycle after the last write
    for (int i = 0; i < 6; i++) begin
      apb_write(gpio_bus_pkg::MODE, rand_word(), '1);
      apb_write(gpio_bus_pkg::DIRECTION, rand_word(), '1);
      apb_write(gpio_bus_pkg::OUTPUT, rand_word(), '1);
      wait_cycles(1);
      post_word($sformatf("gpio_o %0d", i), ref_model(K_GPIO_O, pins_now, pins_now), gpio_o);
      post_word($sformatf("gpio_oe %0d", i), ref_model(K_GPIO_OE, pins_now, pins_now), gpio_oe);
    end

    // Input sampling
    for (int i = 0; i < 4; i++) begin
      drive_pins(rand_word());
      read_check($sformatf("input %0d", i), gpio_bus_pkg::INPUT);
    end

    // Level triggers from a clean state
    apb_write(gpio_bus_pkg::TR_TYPE, '0, '1);
    apb_write(gpio_bus_pkg::TR_LVL0, '0, '1);
    apb_write(gpio_bus_pkg::TR_LVL1, '0, '1);
    apb_write(gpio_bus_pkg::IRQ_ENA, '0, '1);
    apb_write(gpio_bus_pkg::TR_STAT, '1, '1);
    read_check("level cleared", gpio_bus_pkg::TR_STAT);
    apb_write(gpio_bus_pkg::TR_LVL0, rand_word(), '1);
    apb_write(gpio_bus_pkg::TR_LVL1, rand_word(), '1);
    read_check("level set", gpio_bus_pkg::TR_STAT);
    // Earlier matches must stick when the pins invert
    drive_pins(~pins_now);
    read_check("level sticky", gpio_bus_pkg::TR_STAT);
    apb_write(gpio_bus_pkg::TR_STAT, '1, STRB_W'($random(seed)));
    read_check("level strobed clear", gpio_bus_pkg::TR_STAT);

    // Edge triggers with pin 0 enabled both ways
    apb_write(gpio_bus_pkg::TR_LVL0, '0, '1);
    apb_write(gpio_bus_pkg::TR_LVL1, '0, '1);
    apb_write(gpio_bus_pkg::TR_TYPE, '1, '1);
    apb_write(gpio_bus_pkg::TR_STAT, '1, '1);
    read_check("edge cleared", gpio_bus_pkg::TR_STAT);
    apb_write(gpio_bus_pkg::TR_LVL0, rand_word() | PDATA_SIZE'(1), '1);
    apb_write(gpio_bus_pkg::TR_LVL1, rand_word() | PDATA_SIZE'(1), '1);
    flip = rand_word() | PDATA_SIZE'(1);
    drive_pins(pins_now ^ flip);
    read_check("edge toggle", gpio_bus_pkg::TR_STAT);
    drive_pins(pins_now ^ flip);
    read_check("edge toggle back", gpio_bus_pkg::TR_STAT);

    // Interrupt masked, enabled, then cleared
    wait_cycles(3);
    post_bit("irq masked", ref_model(K_IRQ, pins_now, pins_now), irq);
    apb_write(gpio_bus_pkg::IRQ_ENA, '1, '1);
    wait_cycles(3);
    post_bit("irq enabled", ref_model(K_IRQ, pins_now, pins_now), irq);
    apb_write(gpio_bus_pkg::TR_STAT, '1, '1);
    wait_cycles(3);
    post_bit("irq cleared", ref_model(K_IRQ, pins_now, pins_now), irq);

    // Let the compare process catch up
    repeat (3) @(posedge PCLK);
    $display("Checks passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb/gpio_tb_clk.sv
/*
 * Clock and reset source for the GPIO testbench
 */
module gpio_tb_clk #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic PCLK,
  output logic PRESETn
);

  initial begin
    PCLK = 1'b0;
    forever #(PERIOD / 2) PCLK = ~PCLK;
  end

  // Reset released on a rising edge
  initial begin
    PRESETn = 1'b0;
    repeat (RESET_CYCLES) @(posedge PCLK);
    PRESETn <= 1'b1;
  end

endmodule

//--- verilog.f
src/gpio_bus_pkg.sv
src/gpio_pin_pkg.sv
src/gpio_apb_regs.sv
src/gpio_pin_io.sv
src/gpio_trigger.sv
src/gpio_apb_top.sv
tb/gpio_tb_clk.sv
tb/gpio_tb.sv
